// File: design/rv_pkg.sv
package rv_pkg;

  // machine word width
  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [31:0]     insn_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [6:0]      opcode_t;

  // major opcodes of the kept subset
  localparam opcode_t op_lui     = 7'b0110111;
  localparam opcode_t op_reg_imm = 7'b0010011;
  localparam opcode_t op_reg_reg = 7'b0110011;
  localparam opcode_t op_branch  = 7'b1100011;
  localparam opcode_t op_environ = 7'b1110011;

  // funct7 values, alt selects sub and sra
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;

  // funct3 for integer operations
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // funct3 for conditional branches
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    // lui passes the upper immediate straight through
    alu_pass_b
  } alu_op_e;

  typedef enum logic [2:0] {
    br_none,
    br_eq,
    br_ne,
    br_lt,
    br_ge,
    br_ltu,
    br_geu
  } branch_cond_e;

endpackage

// File: design/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder #(
  parameter int num_regs = 32
) (
  input  rv_pkg::insn_t        insn,
  output rv_pkg::reg_addr_t    rs1_addr,
  output rv_pkg::reg_addr_t    rs2_addr,
  output rv_pkg::reg_addr_t    rd_addr,
  output rv_pkg::word_t        imm,
  output rv_pkg::alu_op_e      alu_op,
  output logic                 use_imm,
  output logic                 reg_write,
  output rv_pkg::branch_cond_e branch_cond,
  output logic                 is_ecall,
  output logic                 illegal
);

  rv_pkg::opcode_t opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  rv_pkg::word_t   imm_i;
  rv_pkg::word_t   imm_b;
  rv_pkg::word_t   imm_u;
  logic            needs_rs1;
  logic            needs_rs2;
  logic            needs_rd;

  assign opcode   = insn[6:0];
  assign rd_addr  = insn[11:7];
  assign funct3   = insn[14:12];
  assign rs1_addr = insn[19:15];
  assign rs2_addr = insn[24:20];
  assign funct7   = insn[31:25];

  // immediates are sign-extended and b-type scrambles its bits across the word
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    imm         = imm_i;
    alu_op      = rv_pkg::alu_add;
    use_imm     = 1'b0;
    reg_write   = 1'b0;
    branch_cond = rv_pkg::br_none;
    is_ecall    = 1'b0;
    illegal     = 1'b0;
    needs_rs1   = 1'b0;
    needs_rs2   = 1'b0;
    needs_rd    = 1'b0;

    case (opcode)
      rv_pkg::op_lui: begin
        imm       = imm_u;
        alu_op    = rv_pkg::alu_pass_b;
        use_imm   = 1'b1;
        reg_write = 1'b1;
        needs_rd  = 1'b1;
      end
      rv_pkg::op_reg_imm, rv_pkg::op_reg_reg: begin
        use_imm   = (opcode == rv_pkg::op_reg_imm);
        reg_write = 1'b1;
        needs_rs1 = 1'b1;
        needs_rs2 = (opcode == rv_pkg::op_reg_reg);
        needs_rd  = 1'b1;
        // register forms always carry a funct7 while immediate forms carry one only for shifts
        if (opcode == rv_pkg::op_reg_reg && funct7 != rv_pkg::funct7_base &&
            !(funct7 == rv_pkg::funct7_alt &&
              (funct3 == rv_pkg::f3_add_sub || funct3 == rv_pkg::f3_srl_sra))) begin
          illegal = 1'b1;
        end
        case (funct3)
          rv_pkg::f3_add_sub: begin
            alu_op = (opcode == rv_pkg::op_reg_reg && funct7 == rv_pkg::funct7_alt) ?
                     rv_pkg::alu_sub : rv_pkg::alu_add;
          end
          rv_pkg::f3_sll: begin
            alu_op = rv_pkg::alu_sll;
            if (funct7 != rv_pkg::funct7_base) illegal = 1'b1;
          end
          rv_pkg::f3_slt:  alu_op = rv_pkg::alu_slt;
          rv_pkg::f3_sltu: alu_op = rv_pkg::alu_sltu;
          rv_pkg::f3_xor:  alu_op = rv_pkg::alu_xor;
          rv_pkg::f3_srl_sra: begin
            alu_op = (funct7 == rv_pkg::funct7_alt) ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            if (funct7 != rv_pkg::funct7_base && funct7 != rv_pkg::funct7_alt) begin
              illegal = 1'b1;
            end
          end
          rv_pkg::f3_or:   alu_op = rv_pkg::alu_or;
          rv_pkg::f3_and:  alu_op = rv_pkg::alu_and;
        endcase
      end
      rv_pkg::op_branch: begin
        imm       = imm_b;
        needs_rs1 = 1'b1;
        needs_rs2 = 1'b1;
        case (funct3)
          rv_pkg::f3_beq:  branch_cond = rv_pkg::br_eq;
          rv_pkg::f3_bne:  branch_cond = rv_pkg::br_ne;
          rv_pkg::f3_blt:  branch_cond = rv_pkg::br_lt;
          rv_pkg::f3_bge:  branch_cond = rv_pkg::br_ge;
          rv_pkg::f3_bltu: branch_cond = rv_pkg::br_ltu;
          rv_pkg::f3_bgeu: branch_cond = rv_pkg::br_geu;
          default:         illegal = 1'b1;
        endcase
      end
      rv_pkg::op_environ: begin
        // only ecall is kept and every field above the opcode must be zero
        if (insn[31:7] == '0) is_ecall = 1'b1;
        else illegal = 1'b1;
      end
      default: illegal = 1'b1;
    endcase

    // rv32e builds reject the upper register indices
    if ((needs_rs1 && int'(rs1_addr) >= num_regs) ||
        (needs_rs2 && int'(rs2_addr) >= num_regs) ||
        (needs_rd && int'(rd_addr) >= num_regs)) begin
      illegal = 1'b1;
    end

    if (illegal) begin
      reg_write   = 1'b0;
      branch_cond = rv_pkg::br_none;
    end
  end

endmodule

// File: design/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  rv_pkg::alu_op_e op,
  output rv_pkg::word_t   result
);

  logic [4:0]    shamt;
  logic          lt_signed;
  logic          lt_unsigned;
  rv_pkg::word_t sum;
  rv_pkg::word_t diff;

  // only the low five bits of b count as a shift amount
  assign shamt = b[4:0];

  assign sum  = a + b;
  assign diff = a - b;

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      rv_pkg::alu_add: begin
        result = sum;
      end
      rv_pkg::alu_sub: begin
        result = diff;
      end
      rv_pkg::alu_sll: begin
        result = a << shamt;
      end
      rv_pkg::alu_slt: begin
        result = {31'b0, lt_signed};
      end
      rv_pkg::alu_sltu: begin
        result = {31'b0, lt_unsigned};
      end
      rv_pkg::alu_xor: begin
        result = a ^ b;
      end
      rv_pkg::alu_srl: begin
        result = a >> shamt;
      end
      rv_pkg::alu_sra: begin
        // arithmetic shift keeps the sign bit
        result = rv_pkg::word_t'($signed(a) >>> shamt);
      end
      rv_pkg::alu_or: begin
        result = a | b;
      end
      rv_pkg::alu_and: begin
        result = a & b;
      end
      rv_pkg::alu_pass_b: begin
        result = b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

// File: design/rv_branch_unit.sv
`timescale 1ns/1ps

module rv_branch_unit (
  input  rv_pkg::word_t        pc,
  input  rv_pkg::word_t        rs1_data,
  input  rv_pkg::word_t        rs2_data,
  input  rv_pkg::word_t        imm,
  input  rv_pkg::branch_cond_e cond,
  output rv_pkg::word_t        next_pc,
  output logic                 taken
);

  logic equal;
  logic lt_signed;
  logic lt_unsigned;

  assign equal       = rs1_data == rs2_data;
  assign lt_signed   = $signed(rs1_data) < $signed(rs2_data);
  assign lt_unsigned = rs1_data < rs2_data;

  always_comb begin
    case (cond)
      rv_pkg::br_eq:  taken = equal;
      rv_pkg::br_ne:  taken = !equal;
      rv_pkg::br_lt:  taken = lt_signed;
      rv_pkg::br_ge:  taken = !lt_signed;
      rv_pkg::br_ltu: taken = lt_unsigned;
      rv_pkg::br_geu: taken = !lt_unsigned;
      default:        taken = 1'b0;
    endcase
  end

  // not-taken and non-branch instructions fall through to the next word
  assign next_pc = taken ? pc + imm : pc + rv_pkg::word_t'(4);

endmodule

// File: design/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile #(
  parameter int num_regs = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              we,
  input  rv_pkg::reg_addr_t rd_addr,
  input  rv_pkg::word_t     rd_data,
  input  rv_pkg::reg_addr_t rs1_addr,
  input  rv_pkg::reg_addr_t rs2_addr,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data
);

  localparam int idx_w = $clog2(num_regs);

  rv_pkg::word_t regs [num_regs];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_addr != '0 && int'(rd_addr) < num_regs) begin
      regs[rd_addr[idx_w-1:0]] <= rd_data;
    end
  end

  // x0 and indices past the end read as zero
  assign rs1_data = (rs1_addr == '0 || int'(rs1_addr) >= num_regs) ?
                    '0 : regs[rs1_addr[idx_w-1:0]];
  assign rs2_data = (rs2_addr == '0 || int'(rs2_addr) >= num_regs) ?
                    '0 : regs[rs2_addr[idx_w-1:0]];

endmodule

// File: design/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
  parameter int            num_regs = 32,
  parameter rv_pkg::word_t reset_pc = '0
) (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::insn_t     insn,
  output rv_pkg::word_t     pc,
  output logic              halt,
  output logic              illegal_insn,
  output rv_pkg::word_t     trace_pc,
  output rv_pkg::insn_t     trace_insn,
  output logic              wb_en,
  output rv_pkg::reg_addr_t wb_addr,
  output rv_pkg::word_t     wb_data
);

  rv_pkg::reg_addr_t    rs1_addr;
  rv_pkg::reg_addr_t    rs2_addr;
  rv_pkg::reg_addr_t    rd_addr;
  rv_pkg::word_t        imm;
  rv_pkg::alu_op_e      alu_op;
  logic                 use_imm;
  logic                 reg_write;
  rv_pkg::branch_cond_e branch_cond;
  logic                 is_ecall;
  rv_pkg::word_t        rs1_data;
  rv_pkg::word_t        rs2_data;
  rv_pkg::word_t        alu_b;
  rv_pkg::word_t        alu_result;
  rv_pkg::word_t        next_pc;
  logic                 branch_taken;

  rv_decoder #(
    .num_regs(num_regs)
  ) decoder_inst (
    .insn        (insn),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rd_addr     (rd_addr),
    .imm         (imm),
    .alu_op      (alu_op),
    .use_imm     (use_imm),
    .reg_write   (reg_write),
    .branch_cond (branch_cond),
    .is_ecall    (is_ecall),
    .illegal     (illegal_insn)
  );

  rv_regfile #(
    .num_regs(num_regs)
  ) regfile_inst (
    .clk      (clk),
    .rst      (rst),
    .we       (wb_en),
    .rd_addr  (rd_addr),
    .rd_data  (alu_result),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // immediate forms and lui take the immediate as second operand
  assign alu_b = use_imm ? imm : rs2_data;

  rv_alu alu_inst (
    .a      (rs1_data),
    .b      (alu_b),
    .op     (alu_op),
    .result (alu_result)
  );

  rv_branch_unit branch_inst (
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .imm      (imm),
    .cond     (branch_cond),
    .next_pc  (next_pc),
    .taken    (branch_taken)
  );

  // ecall freezes the pc until the next reset
  assign halt = is_ecall;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else if (!halt) begin
      pc <= next_pc;
    end
  end

  // a write to x0 is not architectural, so it never shows up
  assign wb_en   = reg_write && rd_addr != '0;
  assign wb_addr = rd_addr;
  assign wb_data = branch_taken ? '0 : alu_result;

  assign trace_pc   = pc;
  assign trace_insn = insn;

endmodule

// File: dv/rv_core_assertions.sv
`timescale 1ns/1ps

module rv_core_assertions (
  input logic              clk,
  input logic              rst,
  input rv_pkg::word_t     pc,
  input logic              halt,
  input logic              wb_en,
  input rv_pkg::reg_addr_t wb_addr
);

  // a halted core must not move its pc
  halt_holds_pc: assert property (@(posedge clk) disable iff (rst) halt |=> $stable(pc))
    else $error("pc changed while halt was high");

  // x0 is never an architectural write target
  no_x0_write: assert property (@(posedge clk) disable iff (rst) !(wb_en && wb_addr == '0))
    else $error("write-back shown for register x0");

  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc is not word aligned");

endmodule

// File: dv/rv_program_table.svh
// each row is an instruction and the write, branch, trap or halt it must show
// reset state, untouched registers read zero
write_row(rtype(0, 3, 2, 0, 1), 1, 32'h0000_0000);
// register-immediate, x1 = -5 and x2 = 100 feed the later rows
write_row(itype(-5, 0, 0, 1), 1, 32'hFFFF_FFFB);
write_row(itype(100, 0, 0, 2), 2, 32'h0000_0064);
write_row(itype(35, 0, 0, 15), 15, 32'h0000_0023);
write_row(itype(-4, 1, 2, 3), 3, 32'h0000_0001);
write_row(itype(-1, 2, 2, 4), 4, 32'h0000_0000);
write_row(itype(-1, 2, 3, 5), 5, 32'h0000_0001);
write_row(itype(-1, 2, 4, 6), 6, 32'hFFFF_FF9B);
write_row(itype(-256, 2, 6, 7), 7, 32'hFFFF_FF64);
write_row(itype('h7F0, 1, 7, 8), 8, 32'h0000_07F0);
write_row(itype(4, 2, 1, 9), 9, 32'h0000_0640);
write_row(itype(28, 1, 5, 10), 10, 32'h0000_000F);
// srai carries funct7 0100000 in the upper immediate bits
write_row(itype('h401, 1, 5, 11), 11, 32'hFFFF_FFFD);
write_row(utype('h80001, 12), 12, 32'h8000_1000);
write_row(itype(-16, 2, 7, 13), 13, 32'h0000_0060);
// register-register, x15 = 35 so shifts use only its low bits (3)
write_row(rtype(0, 2, 1, 0, 14), 14, 32'h0000_005F);
write_row(rtype(32, 2, 1, 0, 16), 16, 32'hFFFF_FF97);
write_row(rtype(0, 15, 2, 1, 17), 17, 32'h0000_0320);
write_row(rtype(0, 2, 1, 2, 18), 18, 32'h0000_0001);
write_row(rtype(0, 2, 1, 3, 19), 19, 32'h0000_0000);
write_row(rtype(0, 2, 1, 4, 20), 20, 32'hFFFF_FF9F);
write_row(rtype(0, 15, 1, 5, 21), 21, 32'h1FFF_FFFF);
write_row(rtype(32, 15, 1, 5, 22), 22, 32'hFFFF_FFFF);
write_row(rtype(0, 2, 1, 6, 23), 23, 32'hFFFF_FFFF);
write_row(rtype(0, 2, 1, 7, 24), 24, 32'h0000_0060);
// x0 swallows the write and still reads zero afterwards
write_row(itype(7, 2, 0, 0), 0, 32'h0000_006B);
write_row(rtype(0, 0, 0, 0, 25), 25, 32'h0000_0000);
// random immediates, results follow from sign extension
ra = $random(seed) % 2048;
rb = $random(seed) % 2048;
write_row(itype(ra, 0, 0, 26), 26, ra);
write_row(itype(rb, 0, 0, 27), 27, rb);
write_row(rtype(0, 27, 26, 0, 28), 28, ra + rb);
write_row(rtype(32, 27, 26, 0, 29), 29, ra - rb);
// branches, x22 = x23 = -1
branch_row(0, 22, 23, 16, 1);
branch_row(0, 1, 2, 16, 0);
branch_row(1, 1, 2, -8, 1);
branch_row(1, 22, 23, 8, 0);
branch_row(4, 1, 2, 12, 1);
branch_row(4, 2, 1, 12, 0);
branch_row(5, 2, 1, 20, 1);
branch_row(5, 1, 2, 20, 0);
branch_row(6, 2, 1, 24, 1);
branch_row(6, 1, 2, 24, 0);
branch_row(7, 1, 2, -16, 1);
branch_row(7, 2, 1, -16, 0);
// mul, ebreak and jal are outside the subset, x30 stays zero
illegal_row(rtype(1, 2, 1, 0, 30));
illegal_row(32'h0010_0073);
illegal_row(32'h0000_006F);
write_row(rtype(0, 0, 30, 0, 31), 31, 32'h0000_0000);
ecall_row();
ecall_row();
ecall_row();

// File: dv/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

  localparam logic [31:0] reset_pc = 32'h0000_0100;

  logic                     clk;
  logic                     rst;
  logic              [31:0] insn;
  rv_pkg::word_t            pc;
  logic                     halt;
  logic                     illegal_insn;
  rv_pkg::word_t            trace_pc;
  rv_pkg::insn_t            trace_insn;
  logic                     wb_en;
  rv_pkg::reg_addr_t        wb_addr;
  rv_pkg::word_t            wb_data;

  logic [31:0] insn_q[$];
  logic [31:0] pc_q[$];
  logic [31:0] data_q[$];
  logic [4:0]  addr_q[$];
  logic        wb_en_q[$];
  logic        halt_q[$];
  logic        ill_q[$];
  logic [31:0] build_pc;
  int          num_rows;
  int          seed = 9715;
  int          checks;
  int          errors;

  rv_core #(
    .num_regs(32),
    .reset_pc(reset_pc)
  ) rv_core_inst (
    .clk          (clk),
    .rst          (rst),
    .insn         (insn),
    .pc           (pc),
    .halt         (halt),
    .illegal_insn (illegal_insn),
    .trace_pc     (trace_pc),
    .trace_insn   (trace_insn),
    .wb_en        (wb_en),
    .wb_addr      (wb_addr),
    .wb_data      (wb_data)
  );

  bind rv_core rv_core_assertions assertions_inst (
    .clk(clk), .rst(rst), .pc(pc), .halt(halt), .wb_en(wb_en), .wb_addr(wb_addr)
  );

  always #4 clk = ~clk;

  // instruction encoders in ISA field order
  function automatic logic [31:0] itype(int imm, int rs1, int f3, int rd);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
  endfunction

  function automatic logic [31:0] rtype(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] utype(int upper, int rd);
    return {upper[19:0], rd[4:0], 7'b0110111};
  endfunction

  task automatic row(logic [31:0] word, logic en, logic [4:0] addr, logic [31:0] data,
                     logic hlt, logic ill, int step);
    insn_q.push_back(word);
    pc_q.push_back(build_pc);
    wb_en_q.push_back(en);
    addr_q.push_back(addr);
    data_q.push_back(data);
    halt_q.push_back(hlt);
    ill_q.push_back(ill);
    build_pc = build_pc + step;
  endtask

  task automatic write_row(logic [31:0] word, int rd, logic [31:0] data);
    row(word, rd != 0, rd[4:0], data, 1'b0, 1'b0, 4);
  endtask

  task automatic branch_row(int f3, int rs1, int rs2, int off, logic taken);
    logic [31:0] word;
    word = {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
    row(word, 1'b0, 5'd0, 32'd0, 1'b0, 1'b0, taken ? off : 4);
  endtask

  task automatic illegal_row(logic [31:0] word);
    row(word, 1'b0, 5'd0, 32'd0, 1'b0, 1'b1, 4);
  endtask

  // a halted core keeps fetching the same ecall
  task automatic ecall_row();
    row(32'h0000_0073, 1'b0, 5'd0, 32'd0, 1'b1, 1'b0, 0);
  endtask

  task automatic load_program();
    int ra;
    int rb;
    `include "rv_program_table.svh"
  endtask

  task automatic check(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  initial begin : watchdog
    wait (num_rows > 0);
    #((16 + num_rows + 10) * 8);
    $display("timeout: the instruction table did not finish in time");
    $display("Verification failed");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    // nop is addi x0, x0, 0
    insn = 32'h0000_0013;
    checks = 0;
    errors = 0;
    build_pc = reset_pc;
    load_program();
    num_rows = insn_q.size();
    repeat (16) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < num_rows; i++) begin
      check("pc", pc_q[i], pc);
      insn = insn_q[i];
      #1;
      check("trace_pc", pc_q[i], trace_pc);
      check("trace_insn", insn_q[i], trace_insn);
      check("wb_en", 32'(wb_en_q[i]), 32'(wb_en));
      check("halt", 32'(halt_q[i]), 32'(halt));
      check("illegal_insn", 32'(ill_q[i]), 32'(illegal_insn));
      if (wb_en_q[i]) begin
        check("wb_addr", 32'(addr_q[i]), 32'(wb_addr));
        check("wb_data", data_q[i], wb_data);
      end
      @(negedge clk);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+dv
design/rv_pkg.sv
design/rv_decoder.sv
design/rv_alu.sv
design/rv_branch_unit.sv
design/rv_regfile.sv
design/rv_core.sv
dv/rv_core_assertions.sv
dv/rv_core_tb.sv

// File: Makefile
TOP = rv_core_tb

all: run

build:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "Verification passed" sim.log

lint:
	verilator --lint-only -Wall --timing --assert -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
